/* Makefile */
# verilator build and run for the vpu testbench

VERILATOR ?= verilator
TOP       ?= tb_vpu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit code does not
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/bias_stage.sv */
module bias_stage (
    input  logic            clk,
    input  logic            rst,
    input  vpu_pkg::fixed_t data,
    input  logic            valid,
    input  vpu_pkg::fixed_t bias,
    output vpu_pkg::fixed_t z,
    output logic            z_valid
);
    import vpu_pkg::*;

    // z = data + bias, clamped at both ends
    fixed_t sum;

    assign sum = sat_add(data, bias);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z       <= '0;
            z_valid <= 1'b0;
        end else begin
            z_valid <= valid;
            // result only moves on a beat
            if (valid) begin
                z <= sum;
            end
        end
    end

    // every output beat comes from an input beat one cycle earlier
    assert property (@(posedge clk) disable iff (rst) z_valid |-> $past(valid));

endmodule

/* design/leaky_relu_derivative_stage.sv */
module leaky_relu_derivative_stage (
    input  logic            clk,
    input  logic            rst,
    input  vpu_pkg::fixed_t grad,
    input  logic            valid,
    input  vpu_pkg::fixed_t h,
    input  vpu_pkg::fixed_t leak_factor,
    output vpu_pkg::fixed_t grad_out,
    output logic            grad_out_valid
);
    import vpu_pkg::*;

    // slope of leaky relu at h, times the incoming gradient
    fixed_t gated;

    // h == 0 takes the leaky slope
    assign gated = (h > 0) ? grad : fixed_mul(grad, leak_factor);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grad_out       <= '0;
            grad_out_valid <= 1'b0;
        end else begin
            grad_out_valid <= valid;
            // h sampled together with the gradient beat
            if (valid) begin
                grad_out <= gated;
            end
        end
    end

    // one clock from input strobe to output strobe
    assert property (@(posedge clk) disable iff (rst)
        grad_out_valid |-> $past(valid));

endmodule

/* design/leaky_relu_stage.sv */
module leaky_relu_stage (
    input  logic            clk,
    input  logic            rst,
    input  vpu_pkg::fixed_t data,
    input  logic            valid,
    input  vpu_pkg::fixed_t leak_factor,
    output vpu_pkg::fixed_t h,
    output logic            h_valid
);
    import vpu_pkg::*;

    fixed_t act;

    // sign bit picks the leaky slope, zero passes through
    assign act = data[15] ? fixed_mul(data, leak_factor) : data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h       <= '0;
            h_valid <= 1'b0;
        end else begin
            h_valid <= valid;
            if (valid) begin
                h <= act;
            end
        end
    end

    // one clock from input strobe to output strobe
    assert property (@(posedge clk) disable iff (rst) h_valid |-> $past(valid));

endmodule

/* design/mse_loss_stage.sv */
module mse_loss_stage (
    input  logic            clk,
    input  logic            rst,
    input  vpu_pkg::fixed_t h,
    input  logic            valid,
    input  vpu_pkg::fixed_t y_target,
    input  vpu_pkg::fixed_t inv_batch_x2,
    output vpu_pkg::fixed_t gradient,
    output logic            gradient_valid
);
    import vpu_pkg::*;

    // d(mse)/dh = (2 / batch) * (h - y)
    fixed_t diff;
    fixed_t scaled;

    // difference saturates first, then the scale
    assign diff   = sat_sub(h, y_target);
    assign scaled = fixed_mul(diff, inv_batch_x2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gradient       <= '0;
            gradient_valid <= 1'b0;
        end else begin
            gradient_valid <= valid;
            if (valid) begin
                gradient <= scaled;
            end
        end
    end

    // one clock from input strobe to output strobe
    assert property (@(posedge clk) disable iff (rst)
        gradient_valid |-> $past(valid));

endmodule

/* design/vpu.sv */
module vpu #(
    parameter int LANES = 2
) (
    input  logic              clk,
    input  logic              rst,

    // stage enables, shared by every lane
    input  vpu_pkg::pathway_t pathway,

    // per lane results from the systolic array
    input  vpu_pkg::fixed_t   data_in      [LANES],
    input  logic              valid_in     [LANES],

    // per lane scalars
    input  vpu_pkg::fixed_t   bias_scalar  [LANES],
    input  vpu_pkg::fixed_t   y_target     [LANES],
    input  vpu_pkg::fixed_t   h_saved      [LANES],

    // shared scalars
    input  vpu_pkg::fixed_t   leak_factor,
    input  vpu_pkg::fixed_t   inv_batch_x2,

    // per lane results
    output vpu_pkg::fixed_t   data_out     [LANES],
    output logic              valid_out    [LANES]
);

    // lanes never talk to each other
    // only pathway and the shared scalars fan out to all of them
    for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
        vpu_lane u_lane (
            .clk          (clk),
            .rst          (rst),
            .pathway      (pathway),
            .data_in      (data_in[lane]),
            .valid_in     (valid_in[lane]),
            .bias_scalar  (bias_scalar[lane]),
            .leak_factor  (leak_factor),
            .y_target     (y_target[lane]),
            .inv_batch_x2 (inv_batch_x2),
            .h_saved      (h_saved[lane]),
            .data_out     (data_out[lane]),
            .valid_out    (valid_out[lane])
        );
    end

endmodule

/* design/vpu_lane.sv */
module vpu_lane (
    input  logic              clk,
    input  logic              rst,
    input  vpu_pkg::pathway_t pathway,
    input  vpu_pkg::fixed_t   data_in,
    input  logic              valid_in,
    input  vpu_pkg::fixed_t   bias_scalar,
    input  vpu_pkg::fixed_t   leak_factor,
    input  vpu_pkg::fixed_t   y_target,
    input  vpu_pkg::fixed_t   inv_batch_x2,
    input  vpu_pkg::fixed_t   h_saved,
    output vpu_pkg::fixed_t   data_out,
    output logic              valid_out
);
    import vpu_pkg::*;

    // stage inputs, zeroed when the stage is switched out
    fixed_t bias_data;
    logic   bias_valid;
    fixed_t lrelu_data;
    logic   lrelu_valid;
    fixed_t loss_data;
    logic   loss_valid;
    fixed_t lrd_data;
    logic   lrd_valid;
    fixed_t lrd_h;

    // stage outputs
    fixed_t bias_z;
    logic   bias_z_valid;
    fixed_t lrelu_h;
    logic   lrelu_h_valid;
    fixed_t loss_grad;
    logic   loss_grad_valid;
    fixed_t lrd_grad;
    logic   lrd_grad_valid;

    // chain points between stages, stage result or bypass wire
    fixed_t after_bias_data;
    logic   after_bias_valid;
    fixed_t after_lrelu_data;
    logic   after_lrelu_valid;
    fixed_t after_loss_data;
    logic   after_loss_valid;
    fixed_t after_lrd_data;
    logic   after_lrd_valid;

    // last h, lrelu result delayed one cycle to meet the loss result
    fixed_t last_h;

    always_comb begin
        // bias
        bias_data         = pathway[PATH_BIAS] ? data_in : '0;
        bias_valid        = pathway[PATH_BIAS] & valid_in;
        after_bias_data   = pathway[PATH_BIAS] ? bias_z : data_in;
        after_bias_valid  = pathway[PATH_BIAS] ? bias_z_valid : valid_in;

        // leaky relu
        lrelu_data        = pathway[PATH_LRELU] ? after_bias_data : '0;
        lrelu_valid       = pathway[PATH_LRELU] & after_bias_valid;
        after_lrelu_data  = pathway[PATH_LRELU] ? lrelu_h : after_bias_data;
        after_lrelu_valid = pathway[PATH_LRELU] ? lrelu_h_valid : after_bias_valid;

        // loss gradient
        loss_data         = pathway[PATH_LOSS] ? after_lrelu_data : '0;
        loss_valid        = pathway[PATH_LOSS] & after_lrelu_valid;
        after_loss_data   = pathway[PATH_LOSS] ? loss_grad : after_lrelu_data;
        after_loss_valid  = pathway[PATH_LOSS] ? loss_grad_valid : after_lrelu_valid;

        // lrelu derivative, h from cache in transition mode, else external
        lrd_data          = pathway[PATH_LRELU_D] ? after_loss_data : '0;
        lrd_valid         = pathway[PATH_LRELU_D] & after_loss_valid;
        lrd_h             = pathway[PATH_LOSS] ? last_h : h_saved;
        after_lrd_data    = pathway[PATH_LRELU_D] ? lrd_grad : after_loss_data;
        after_lrd_valid   = pathway[PATH_LRELU_D] ? lrd_grad_valid : after_loss_valid;
    end

    // outputs held low during reset
    assign data_out  = rst ? '0 : after_lrd_data;
    assign valid_out = rst ? 1'b0 : after_lrd_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_h <= '0;
        end else if (pathway[PATH_LOSS]) begin
            last_h <= lrelu_h;
        end else begin
            last_h <= '0;
        end
    end

    bias_stage u_bias (
        .clk     (clk),
        .rst     (rst),
        .data    (bias_data),
        .valid   (bias_valid),
        .bias    (bias_scalar),
        .z       (bias_z),
        .z_valid (bias_z_valid)
    );

    leaky_relu_stage u_lrelu (
        .clk         (clk),
        .rst         (rst),
        .data        (lrelu_data),
        .valid       (lrelu_valid),
        .leak_factor (leak_factor),
        .h           (lrelu_h),
        .h_valid     (lrelu_h_valid)
    );

    mse_loss_stage u_loss (
        .clk            (clk),
        .rst            (rst),
        .h              (loss_data),
        .valid          (loss_valid),
        .y_target       (y_target),
        .inv_batch_x2   (inv_batch_x2),
        .gradient       (loss_grad),
        .gradient_valid (loss_grad_valid)
    );

    leaky_relu_derivative_stage u_lrelu_d (
        .clk            (clk),
        .rst            (rst),
        .grad           (lrd_data),
        .valid          (lrd_valid),
        .h              (lrd_h),
        .leak_factor    (leak_factor),
        .grad_out       (lrd_grad),
        .grad_out_valid (lrd_grad_valid)
    );

    // no x on the output strobe once out of reset
    assert property (@(posedge clk) disable iff (rst) !$isunknown(valid_out));

    // all stages off, strobe is a straight wire
    assert property (@(posedge clk) disable iff (rst)
        (pathway == '0) |-> (valid_out == valid_in));

endmodule

/* design/vpu_pkg.sv */
package vpu_pkg;

    // q8.8 signed data word
    typedef logic signed [15:0] fixed_t;

    // full product of two q8.8 words, also wide enough for sums
    typedef logic signed [31:0] product_t;

    // stage enables, one bit per stage
    typedef logic [3:0] pathway_t;

    localparam int FRAC_BITS = 8;

    // bit positions inside pathway_t, stage order msb first
    localparam int PATH_BIAS    = 3;
    localparam int PATH_LRELU   = 2;
    localparam int PATH_LOSS    = 1;
    localparam int PATH_LRELU_D = 0;

    localparam fixed_t FIXED_MAX = fixed_t'(16'h7fff);
    localparam fixed_t FIXED_MIN = fixed_t'(16'h8000);

    // clamp a wide intermediate into the q8.8 range
    function automatic fixed_t sat_to_fixed(input product_t value);
        if (value > product_t'(FIXED_MAX)) begin
            return FIXED_MAX;
        end
        if (value < product_t'(FIXED_MIN)) begin
            return FIXED_MIN;
        end
        return fixed_t'(value);
    endfunction

    function automatic fixed_t sat_add(input fixed_t a, input fixed_t b);
        return sat_to_fixed(product_t'(a) + product_t'(b));
    endfunction

    function automatic fixed_t sat_sub(input fixed_t a, input fixed_t b);
        return sat_to_fixed(product_t'(a) - product_t'(b));
    endfunction

    // q16.16 product back to q8.8, arithmetic shift floors toward -inf
    function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
        product_t prod;
        prod = product_t'(a) * product_t'(b);
        return sat_to_fixed(prod >>> FRAC_BITS);
    endfunction

endpackage

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release on a falling edge, away from the sampling edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* sim/tb_vpu.sv */
module tb_vpu;
    import vpu_pkg::*;

    localparam int LANES       = 2;
    localparam int CLK_PERIOD  = 40;
    localparam int MEM_WORDS   = 512;
    // record sizes in the cases file, kind word included
    localparam int GROUP_WORDS = 10;
    localparam int ITEM_WORDS  = 7;

    logic     clk;
    logic     rst;
    pathway_t pathway;
    fixed_t   data_in      [LANES];
    logic     valid_in     [LANES];
    fixed_t   bias_scalar  [LANES];
    fixed_t   y_target     [LANES];
    fixed_t   h_saved      [LANES];
    fixed_t   leak_factor;
    fixed_t   inv_batch_x2;
    fixed_t   data_out     [LANES];
    logic     valid_out    [LANES];

    logic [15:0] cases_mem [MEM_WORDS];
    // expected results per lane, oldest first
    fixed_t exp_q0 [$];
    fixed_t exp_q1 [$];
    // arrival cycle per expected beat, same order as the values
    int     due_q0 [$];
    int     due_q1 [$];
    // rising edges seen so far
    int     cycle_cnt;
    int     sent_cnt [LANES];
    int     got_cnt  [LANES];
    int     pass_cnt;
    int     fail_cnt;
    int     item_total;
    int     group_total;
    longint limit;
    logic   limit_ready;
    // low until the first group is driven, outputs must stay quiet
    logic   started;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rst(rst));

    vpu #(.LANES(LANES)) u_dut (
        .clk          (clk),
        .rst          (rst),
        .pathway      (pathway),
        .data_in      (data_in),
        .valid_in     (valid_in),
        .bias_scalar  (bias_scalar),
        .y_target     (y_target),
        .h_saved      (h_saved),
        .leak_factor  (leak_factor),
        .inv_batch_x2 (inv_batch_x2),
        .data_out     (data_out),
        .valid_out    (valid_out)
    );

    task automatic check_value(input string name, input int lane, input logic [15:0] expected,
                               input logic [15:0] got);
        assert (got === expected) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Fail t=%0t %s[%0d] expected %h got %h", $time, name, lane, expected, got);
        end
    endtask

    task automatic check_arrival(input int lane, input int expected, input int got);
        assert (got == expected) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("Fail t=%0t valid_out[%0d] expected cycle %0d got cycle %0d",
                     $time, lane, expected, got);
        end
    endtask

    // one clock per enabled stage, none with every stage off
    function automatic int path_latency(input pathway_t path);
        int n;
        n = 0;
        for (int b = 0; b < 4; b++) begin
            if (path[b]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic push_expected(input int lane, input fixed_t value, input int due);
        if (lane == 0) begin
            exp_q0.push_back(value);
            due_q0.push_back(due);
        end else begin
            exp_q1.push_back(value);
            due_q1.push_back(due);
        end
    endtask

    function automatic fixed_t pop_expected(input int lane);
        if (lane == 0) begin
            return exp_q0.pop_front();
        end
        return exp_q1.pop_front();
    endfunction

    function automatic int pop_due(input int lane);
        if (lane == 0) begin
            return due_q0.pop_front();
        end
        return due_q1.pop_front();
    endfunction

    function automatic int pending_count(input int lane);
        if (lane == 0) begin
            return exp_q0.size();
        end
        return exp_q1.size();
    endfunction

    // walk the records once, for the watchdog budget
    task automatic count_cases();
        int p;
        p = 0;
        item_total = 0;
        group_total = 0;
        while (p < MEM_WORDS && (cases_mem[p] == 16'h0001 || cases_mem[p] == 16'h0002)) begin
            if (cases_mem[p] == 16'h0001) begin
                group_total++;
                p += GROUP_WORDS;
            end else begin
                item_total++;
                p += ITEM_WORDS;
            end
        end
    endtask

    task automatic drive_scalars(input int p);
        pathway        = cases_mem[p + 1][3:0];
        bias_scalar[0] = cases_mem[p + 2];
        bias_scalar[1] = cases_mem[p + 3];
        leak_factor    = cases_mem[p + 4];
        y_target[0]    = cases_mem[p + 5];
        y_target[1]    = cases_mem[p + 6];
        inv_batch_x2   = cases_mem[p + 7];
        h_saved[0]     = cases_mem[p + 8];
        h_saved[1]     = cases_mem[p + 9];
    endtask

    // item layout: valid0 data0 valid1 data1 expect0 expect1
    task automatic drive_item(input int p);
        int due;
        // beat enters at the next edge, each enabled stage adds one edge
        due = cycle_cnt + path_latency(pathway);
        for (int lane = 0; lane < LANES; lane++) begin
            valid_in[lane] = cases_mem[p + 1 + 2 * lane][0];
            data_in[lane]  = cases_mem[p + 2 + 2 * lane];
            if (valid_in[lane]) begin
                push_expected(lane, cases_mem[p + 5 + lane], due);
                sent_cnt[lane]++;
            end
        end
    endtask

    task automatic run_group(inout int p, input int group_idx);
        int items;
        int waited;
        int fails_before;
        fails_before = fail_cnt;
        items = 0;
        exp_q0.delete();
        exp_q1.delete();
        due_q0.delete();
        due_q1.delete();
        for (int lane = 0; lane < LANES; lane++) begin
            sent_cnt[lane] = 0;
            got_cnt[lane]  = 0;
        end
        @(negedge clk);
        started = 1'b1;
        drive_scalars(p);
        p += GROUP_WORDS;
        // items back to back, one per cycle
        while (cases_mem[p] == 16'h0002) begin
            @(negedge clk);
            drive_item(p);
            p += ITEM_WORDS;
            items++;
        end
        @(negedge clk);
        for (int lane = 0; lane < LANES; lane++) begin
            valid_in[lane] = 1'b0;
        end
        // drain, deepest pipeline is four stages
        waited = 0;
        while ((pending_count(0) != 0 || pending_count(1) != 0) && waited < 6) begin
            @(negedge clk);
            waited++;
        end
        for (int lane = 0; lane < LANES; lane++) begin
            if (got_cnt[lane] != sent_cnt[lane]) begin
                fail_cnt++;
                $display("group %0d lane %0d returned %0d beats but %0d valid items were sent",
                         group_idx, lane, got_cnt[lane], sent_cnt[lane]);
            end
        end
        $display("group %0d pathway %b, %0d items: %s", group_idx, pathway, items,
                 (fail_cnt == fails_before) ? "ok" : "errors");
    endtask

    // collector, samples the values settled before the rising edge
    always @(posedge clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (!started) begin
                check_value("valid_out", lane, 16'h0000, {15'b0, valid_out[lane]});
                check_value("data_out", lane, 16'h0000, data_out[lane]);
            end else if (valid_out[lane]) begin
                if (pending_count(lane) == 0) begin
                    fail_cnt++;
                    $display("lane %0d gave an output beat at t=%0t with no item waiting",
                             lane, $time);
                end else begin
                    got_cnt[lane]++;
                    check_value("data_out", lane, pop_expected(lane), data_out[lane]);
                    check_arrival(lane, pop_due(lane), cycle_cnt);
                end
            end
        end
        cycle_cnt++;
    end

    initial begin
        int p;
        int group_idx;
        pathway      = 4'b1100;
        leak_factor  = '0;
        inv_batch_x2 = '0;
        for (int lane = 0; lane < LANES; lane++) begin
            data_in[lane]     = '0;
            valid_in[lane]    = 1'b0;
            bias_scalar[lane] = '0;
            y_target[lane]    = '0;
            h_saved[lane]     = '0;
        end
        started     = 1'b0;
        cycle_cnt   = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        limit_ready = 1'b0;
        $readmemh("sim/vpu_cases.txt", cases_mem);
        count_cases();
        limit = longint'(item_total + 6 * group_total + 10) * CLK_PERIOD;
        limit_ready = 1'b1;
        if (group_total == 0) begin
            fail_cnt++;
            $display("the cases file holds no groups");
        end
        // rst only moves on a falling edge
        @(posedge clk);
        while (rst) @(posedge clk);
        p = 0;
        group_idx = 0;
        while (cases_mem[p] == 16'h0001) begin
            run_group(p, group_idx);
            group_idx++;
        end
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog, budget from the item and group counts
    initial begin
        wait (limit_ready === 1'b1);
        #(limit);
        $display("timeout, the run did not finish within %0d time units", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* sim/vpu_cases.txt */
// group: 0001 pathway bias0 bias1 leak y0 y1 inv_batch_x2 h0 h1
// item:  0002 valid0 data0 valid1 data1 expect0 expect1, a lone 0000 ends the list
// forward 1100, negative inputs, saturation at both ends, flooring
0001 000c 0100 ff00 0020 0000 0000 0080 0000 0000
0002 0001 0200 0001 0080 0300 fff0
0002 0001 fc00 0001 0300 ffa0 0200
0002 0001 7f80 0001 8050 7fff f000
0002 0001 ff00 0001 fff3 0000 ffde
// transition 1111, h signs alternate beat to beat, h_saved must be ignored
0001 000f 0000 0080 0020 0100 ff00 0080 ff00 0100
0002 0001 0300 0001 ff00 0100 000f
0002 0001 fe00 0001 0100 ffec 0140
0002 0001 0040 0001 fd00 ffa0 000b
0002 0001 ff80 0001 0280 ffef 0200
0002 0001 0000 0001 ff80 fff0 0010
// backward 0001, positive and negative h_saved
0001 0001 0000 0000 0020 0000 0000 0080 0100 ff00
0002 0001 0123 0001 0080 0123 0010
0002 0001 fe40 0001 fe40 fe40 ffc8
0002 0001 7fff 0001 ffff 7fff ffff
// backward 0001, zero h takes the leak, tiny positive h passes
0001 0001 0000 0000 0040 0000 0000 0080 0000 0001
0002 0001 0100 0001 0100 0040 0100
0002 0001 ff00 0001 8000 ffc0 8000
// pass-through 0000, one lane idle per item
0001 0000 0000 0000 0020 0000 0000 0080 0000 0000
0002 0001 1234 0001 abcd 1234 abcd
0002 0000 5555 0001 0042 0000 0042
0002 0001 beef 0000 7777 beef 0000
// forward 1100 with gaps in either lane
0001 000c 0000 0000 0020 0000 0000 0080 0000 0000
0002 0001 f800 0000 0000 ff00 0000
0002 0000 0000 0001 0400 0000 0400
0002 0001 0010 0001 ffc0 0010 fff8
0000

/* src.f */
design/vpu_pkg.sv
design/bias_stage.sv
design/leaky_relu_stage.sv
design/mse_loss_stage.sv
design/leaky_relu_derivative_stage.sv
design/vpu_lane.sv
design/vpu.sv
sim/tb_clock_gen.sv
sim/tb_vpu.sv
